// ==== compile.f ====
verilog/videoPkg.sv
verilog/cpuBusPkg.sv
verilog/layerCtrlRegs.sv
verilog/videoTiming.sv
verilog/scrollAddrStage.sv
verilog/tileRam.sv
verilog/tileFetchStage.sv
verilog/tilemapGenTop.sv
verification/clockGen.sv
verification/tilemapGenTb.sv

// ==== verification/clockGen.sv ====
`timescale 1ns/1ps

module clockGen (
	output logic CLK_6M,
	output logic rst
);

	// 4 ns period
	initial begin
		CLK_6M = 1'b0;
		forever #2 CLK_6M = ~CLK_6M;
	end

	// reset held for three rising edges
	initial begin
		rst = 1'b1;
		repeat (3) @(posedge CLK_6M);
		rst <= 1'b0;
	end

endmodule

// ==== verification/tilemapGenTb.sv ====
`timescale 1ns/1ps

module tilemapGenTb
	import videoPkg::*;
	import cpuBusPkg::*;
;

	// cycle budgets per test
	// each bus cycle takes 3 clocks
	localparam int BUDGET_RESET = 40;
	localparam int BUDGET_REGS = 120;
	localparam int BUDGET_RAM = (TILE_RAM_DEPTH + 512) * 3;
	localparam int BUDGET_SCROLL = 800;
	localparam int BUDGET_GFX = 1300;
	localparam int BUDGET_LIVE = 250;
	localparam int BUDGET_ALL = BUDGET_RESET + BUDGET_REGS + BUDGET_RAM +
		BUDGET_SCROLL + BUDGET_GFX + BUDGET_LIVE;

	logic CLK_6M;
	logic rst;
	logic nHsync;
	logic nVsync;
	apbReqT apbReq;
	apbRspT apbRsp;
	tileRamAddrT ramAddr;
	gfxOutT gfxOut;
	priorityT [LAYER_COUNT-1:0] layerPriority;

	// model state
	logic [7:0] mRam [0:TILE_RAM_DEPTH-1];
	hScrollT mHs [0:1];
	vScrollT mVs [0:1];
	priorityT mPri [0:1];
	hCountT mH;
	vCountT mV;
	logic mHLast;
	logic mVLast;
	// stage 1 entries with the newest at index 0
	ramReqT hist [0:3];
	apbRspT rspSample;
	tileRamAddrT addrSample;
	logic pipeChk;
	int errors;
	int gfxSeen;
	logic [31:0] seed;

	clockGen u_clockGen (.CLK_6M(CLK_6M), .rst(rst));

	tilemapGenTop u_tilemapGenTop (
		.CLK_6M        (CLK_6M),
		.rst           (rst),
		.nHsync        (nHsync),
		.nVsync        (nVsync),
		.apbReq        (apbReq),
		.apbRsp        (apbRsp),
		.ramAddr       (ramAddr),
		.gfxOut        (gfxOut),
		.layerPriority (layerPriority)
	);

	////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////

	task checkRamAddr(input string name, input tileRamAddrT exp, input tileRamAddrT act);
		if (exp !== act) begin
			errors++;
			$display("FAILED %s expected %h actual %h", name, exp, act);
		end
	endtask

	task checkGfx(input string name, input gfxAddrT exp, input gfxAddrT act);
		if (exp !== act) begin
			errors++;
			$display("FAILED %s expected %h actual %h", name, exp, act);
		end
	endtask

	task checkByte(input string name, input apbDataT exp, input apbDataT act);
		if (exp !== act) begin
			errors++;
			$display("FAILED %s expected %h actual %h", name, exp, act);
		end
	endtask

	task checkPriority(input string name, input priorityT exp, input priorityT act);
		if (exp !== act) begin
			errors++;
			$display("FAILED %s expected %h actual %h", name, exp, act);
		end
	endtask

	task checkFlag(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			errors++;
			$display("FAILED %s expected %h actual %h", name, exp, act);
		end
	endtask

	// lcg with the numerical recipes constants
	function logic [31:0] lcgNext();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// one byte from the upper lcg bits
	function apbDataT randByte();
		logic [31:0] r;
		r = lcgNext();
		return r[23:16];
	endfunction

	function apbAddrT regAddr(input int layer, input logic [1:0] off);
		return {11'b0, layer[0], off};
	endfunction

	////////////////////////////////////////////////////////////
	// clock step with model and pipeline checks
	////////////////////////////////////////////////////////////

	// visible gfxOut comes from the byte 1 entry in hist[2]
	// and takes its index from hist[3]
	task checkGfxSlot();
		logic expValid;
		gfxAddrT expAddr;
		expValid = hist[2].valid && hist[2].addr[0];
		checkFlag("gfxOut.valid", expValid, gfxOut.valid);
		if (expValid && gfxOut.valid) begin
			expAddr = {mRam[hist[2].addr][1:0], mRam[hist[3].addr],
				hist[2].tileRow, hist[2].nibble};
			checkGfx("gfxOut.addr", expAddr, gfxOut.addr);
			checkFlag("gfxOut.layer", hist[2].addr[12], gfxOut.layer);
			gfxSeen++;
		end
	endtask

	task tick();
		ramReqT nextReq;
		hCountT hSum;
		vCountT vSum;
		logic ly;
		logic hFall;
		logic vFall;
		@(posedge CLK_6M);
		// values from before this edge
		rspSample = apbRsp;
		addrSample = ramAddr;
		if (pipeChk && hist[0].valid)
			checkRamAddr("ramAddr", hist[0].addr, ramAddr);
		if (pipeChk)
			checkGfxSlot();
		// stage 1 entry registered at this edge
		ly = mH[1];
		hSum = mH + mHs[ly];
		vSum = mV + {1'b0, mVs[ly]};
		nextReq.valid = 1'b1;
		nextReq.addr = {ly, vSum[7:3], hSum[8:3], mH[0]};
		nextReq.tileRow = vSum[2:0];
		nextReq.nibble = hSum[2];
		if (rst)
			nextReq = '0;
		hist[3] = hist[2];
		hist[2] = hist[1];
		hist[1] = hist[0];
		hist[0] = nextReq;
		// counters from the sync levels driven so far
		hFall = !nHsync && mHLast;
		vFall = !nVsync && mVLast;
		if (rst) begin
			mH = '0;
			mV = '0;
			mHLast = 1'b0;
			mVLast = 1'b0;
		end else begin
			mHLast = nHsync;
			mVLast = nVsync;
			mH = hFall ? hCountT'(0) : mH + 1'b1;
			if (vFall)
				mV = '0;
			else if (hFall)
				mV = mV + 1'b1;
		end
	endtask

	////////////////////////////////////////////////////////////
	// APB cycles
	////////////////////////////////////////////////////////////

	function logic isUnmapped(input apbAddrT a);
		return a < TILE_RAM_BASE && (a[12:3] != '0 || a[1:0] == 2'd3);
	endfunction

	task apbCycle(input logic write, input apbAddrT a, input apbDataT d, output apbDataT rd);
		tick();
		apbReq.psel <= 1'b1;
		apbReq.penable <= 1'b0;
		apbReq.pwrite <= write;
		apbReq.paddr <= a;
		apbReq.pwdata <= d;
		tick();
		apbReq.penable <= 1'b1;
		// access phase is registered at this edge
		tick();
		apbReq.psel <= 1'b0;
		apbReq.penable <= 1'b0;
		rd = rspSample.prdata;
		checkFlag("pready", 1'b1, rspSample.pready);
		checkFlag("pslverr", isUnmapped(a), rspSample.pslverr);
		if (write && !isUnmapped(a)) begin
			if (a >= TILE_RAM_BASE)
				mRam[a[12:0]] = d;
			else if (a[1:0] == 2'd0)
				mHs[a[2]][7:0] = d;
			else if (a[1:0] == 2'd1) begin
				mHs[a[2]][8] = d[0];
				mPri[a[2]] = d[3:1];
			end else
				mVs[a[2]] = d;
		end
	endtask

	task apbWrite(input apbAddrT a, input apbDataT d);
		apbDataT unused;
		apbCycle(1'b1, a, d, unused);
	endtask

	task apbRead(input apbAddrT a, output apbDataT d);
		apbCycle(1'b0, a, 8'h00, d);
	endtask

	task readRegs();
		apbDataT d;
		for (int l = 0; l < 2; l++) begin
			apbRead(regAddr(l, REG_HSCROLL_LO), d);
			checkByte("prdata hScrollLo", mHs[l][7:0], d);
			apbRead(regAddr(l, REG_HSCROLL_HI_PRI), d);
			checkByte("prdata hScrollHiPri", {4'b0, mPri[l], mHs[l][8]}, d);
			apbRead(regAddr(l, REG_VSCROLL), d);
			checkByte("prdata vScroll", mVs[l], d);
			checkPriority("layerPriority", mPri[l], layerPriority[l]);
		end
	endtask

	task syncPulse(input logic h, input logic v);
		if (h)
			nHsync <= 1'b0;
		if (v)
			nVsync <= 1'b0;
		tick();
		tick();
		nHsync <= 1'b1;
		nVsync <= 1'b1;
		tick();
	endtask

	////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////

	task resetTest();
		checkFlag("gfxOut.valid", 1'b0, gfxOut.valid);
		readRegs();
	endtask

	task regTest();
		apbDataT d;
		for (int l = 0; l < 2; l++) begin
			d = randByte();
			apbWrite(regAddr(l, REG_HSCROLL_LO), d);
			d = randByte();
			apbWrite(regAddr(l, REG_HSCROLL_HI_PRI), d);
			d = randByte();
			apbWrite(regAddr(l, REG_VSCROLL), d);
		end
		readRegs();
		// writes to unmapped offsets are dropped
		apbWrite(14'h0003, 8'hff);
		apbWrite(14'h0100, 8'hff);
		apbRead(14'h1ff8, d);
		readRegs();
	endtask

	task ramTest();
		logic [31:0] r;
		apbDataT d;
		for (int a = 0; a < TILE_RAM_DEPTH; a++) begin
			r = lcgNext();
			apbWrite(TILE_RAM_BASE | apbAddrT'(a), r[7:0]);
		end
		for (int i = 0; i < 512; i++) begin
			r = lcgNext();
			apbRead(TILE_RAM_BASE | apbAddrT'(r[12:0]), d);
			checkByte("prdata tileRam", mRam[r[12:0]], d);
		end
	endtask

	task scrollTest();
		logic ly;
		pipeChk = 1'b1;
		for (int l = 0; l < 2; l++) begin
			apbWrite(regAddr(l, REG_HSCROLL_LO), randByte());
			apbWrite(regAddr(l, REG_HSCROLL_HI_PRI), randByte());
			apbWrite(regAddr(l, REG_VSCROLL), randByte());
		end
		syncPulse(1'b1, 1'b0);
		repeat (600) tick();
		// after a frame restart the row comes from vScroll alone
		syncPulse(1'b0, 1'b1);
		ly = hist[1].addr[12];
		checkRamAddr("ramAddr row", {1'b0, mVs[ly][7:3], 7'b0}, addrSample & 13'h0f80);
		repeat (100) tick();
	endtask

	task gfxTest();
		gfxSeen = 0;
		syncPulse(1'b1, 1'b0);
		repeat (1200) tick();
		if (gfxSeen == 0) begin
			errors++;
			$display("no valid graphics ROM address came out of the pipeline");
		end
	endtask

	// scroll writes while the line runs
	task liveTest();
		for (int i = 0; i < 4; i++) begin
			apbWrite(regAddr(1, REG_HSCROLL_LO), randByte());
			apbWrite(regAddr(0, REG_VSCROLL), randByte());
			repeat (40) tick();
		end
	endtask

	////////////////////////////////////////////////////////////
	// main sequence and watchdog
	////////////////////////////////////////////////////////////

	initial begin
		apbReq <= '0;
		nHsync <= 1'b1;
		nVsync <= 1'b1;
		errors = 0;
		pipeChk = 1'b0;
		seed = 32'hb197b20a;
		for (int l = 0; l < 2; l++) begin
			mHs[l] = '0;
			mVs[l] = '0;
			mPri[l] = '0;
		end
		for (int i = 0; i < 4; i++)
			hist[i] = '0;
		tick();
		while (rst)
			tick();
		tick();
		resetTest();
		regTest();
		ramTest();
		scrollTest();
		gfxTest();
		liveTest();
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	initial begin
		#(BUDGET_ALL * 4 + 2000);
		$display("timeout, the tests did not finish in their cycle budget");
		$display("Simulation failed");
		$finish;
	end

endmodule

// ==== verilog/cpuBusPkg.sv ====
package cpuBusPkg;
	import videoPkg::*;

	// APB3, 14 bit byte address, 8 bit data
	typedef logic [13:0] apbAddrT;
	typedef logic [7:0] apbDataT;

	typedef struct packed {
		logic    psel;
		logic    penable;
		logic    pwrite;
		apbAddrT paddr;
		apbDataT pwdata;
	} apbReqT;

	typedef struct packed {
		apbDataT prdata;
		logic    pready;
		logic    pslverr;
	} apbRspT;

	// register offsets in paddr[1:0], paddr[2] picks the layer
	localparam logic [1:0] REG_HSCROLL_LO = 2'd0;
	localparam logic [1:0] REG_HSCROLL_HI_PRI = 2'd1;
	localparam logic [1:0] REG_VSCROLL = 2'd2;
	// tilemap RAM window, upper half of the space
	localparam apbAddrT TILE_RAM_BASE = 14'h2000;

	// CPU side port of the tilemap RAM
	typedef struct packed {
		logic        en;
		logic        we;
		tileRamAddrT addr;
		logic [7:0]  wdata;
	} cpuRamAccessT;

endpackage

// ==== verilog/layerCtrlRegs.sv ====
`timescale 1ns/1ps

module layerCtrlRegs
	import videoPkg::*;
	import cpuBusPkg::*;
(
	input  logic                         CLK_6M,
	input  logic                         rst,
	input  apbReqT                       apbReq,
	output apbRspT                       apbRsp,
	output layerScrollT [LAYER_COUNT-1:0] scroll,
	output priorityT [LAYER_COUNT-1:0]    layerPriority,
	output cpuRamAccessT                 cpuRam,
	input  logic [7:0]                   cpuRamRdata
);

	logic       access;
	logic       isRam;
	logic       regHit;
	logic [1:0] regOff;
	logic       regLayer;
	apbDataT    regRdata;

	////////////////////////////////////////////////////////////
	// address decode
	////////////////////////////////////////////////////////////

	// access phase, completes in the same cycle
	assign access = apbReq.psel && apbReq.penable;
	assign isRam = apbReq.paddr >= TILE_RAM_BASE;
	assign regOff = apbReq.paddr[1:0];
	assign regLayer = apbReq.paddr[2];

	// only offsets 0..2 of each layer block exist
	assign regHit = !isRam && (apbReq.paddr[12:3] == '0) &&
		(regOff == REG_HSCROLL_LO || regOff == REG_HSCROLL_HI_PRI ||
		regOff == REG_VSCROLL);

	////////////////////////////////////////////////////////////
	// scroll and priority registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			scroll <= '0;
			layerPriority <= '0;
		end else if (access && apbReq.pwrite && regHit) begin
			case (regOff)
				REG_HSCROLL_LO: scroll[regLayer].hScroll[7:0] <= apbReq.pwdata;
				REG_HSCROLL_HI_PRI: begin
					// bit 0 is hScroll msb, bits 3:1 priority
					scroll[regLayer].hScroll[8] <= apbReq.pwdata[0];
					layerPriority[regLayer] <= apbReq.pwdata[3:1];
				end
				REG_VSCROLL: scroll[regLayer].vScroll <= apbReq.pwdata;
				default: ;
			endcase
		end
	end

	// register readback
	always_comb begin
		regRdata = '0;
		case (regOff)
			REG_HSCROLL_LO: regRdata = scroll[regLayer].hScroll[7:0];
			REG_HSCROLL_HI_PRI: regRdata = {4'b0, layerPriority[regLayer],
				scroll[regLayer].hScroll[8]};
			REG_VSCROLL: regRdata = scroll[regLayer].vScroll;
			default: regRdata = '0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// bus response and tile RAM forwarding
	////////////////////////////////////////////////////////////

	// RAM read data comes from the combinational CPU port
	assign apbRsp.prdata = !access ? '0 : (isRam ? cpuRamRdata : regRdata);
	// no wait states
	assign apbRsp.pready = 1'b1;
	// unmapped register, write dropped above
	assign apbRsp.pslverr = access && !isRam && !regHit;

	// window offset is just the low 13 bits
	assign cpuRam.en = access && isRam;
	assign cpuRam.we = apbReq.pwrite;
	assign cpuRam.addr = tileRamAddrT'(apbReq.paddr[12:0]);
	assign cpuRam.wdata = apbReq.pwdata;

endmodule

// ==== verilog/scrollAddrStage.sv ====
`timescale 1ns/1ps

module scrollAddrStage
	import videoPkg::*;
(
	input  logic                         CLK_6M,
	input  logic                         rst,
	input  hCountT                       hCount,
	input  vCountT                       vCount,
	input  layerScrollT [LAYER_COUNT-1:0] scroll,
	output ramReqT                       ramReq
);

	// four slots per tile fetch, layer then byte
	logic        slotLayer;
	logic        slotByte;
	layerScrollT curScroll;
	hCountT      hSum;
	vCountT      vSum;
	tileRamAddrT nextAddr;

	assign slotLayer = hCount[1];
	assign slotByte = hCount[0];

	// scroll of the layer owning this slot
	assign curScroll = scroll[slotLayer];

	////////////////////////////////////////////////////////////
	// screen to tilemap space
	////////////////////////////////////////////////////////////

	// both sums wrap, 512 wide
	assign hSum = hCount + curScroll.hScroll;
	assign vSum = vCount + vCountT'(curScroll.vScroll);

	// row from vertical bits 7:3, column from horizontal bits 8:3
	assign nextAddr = {slotLayer, vSum[7:3], hSum[8:3], slotByte};

	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			ramReq <= '0;
		end else begin
			// free running, valid from the first clock out of reset
			ramReq.valid <= 1'b1;
			ramReq.addr <= nextAddr;
			// pixel row inside the tile
			ramReq.tileRow <= vSum[2:0];
			// left or right half of the 8 pixel row
			ramReq.nibble <= hSum[2];
		end
	end

endmodule

// ==== verilog/tileFetchStage.sv ====
`timescale 1ns/1ps

module tileFetchStage
	import videoPkg::*;
(
	input  logic       CLK_6M,
	input  logic       rst,
	input  ramReqT     ramReq,
	input  logic [7:0] ramData,
	output gfxOutT     gfxOut
);

	// request delayed to match the RAM read latency
	ramReqT    reqD;
	tileIndexT tileIndex;
	tileAttrT  tileAttr;
	logic      indexSlot;
	logic      attrSlot;
	gfxAddrT   nextGfxAddr;

	// byte 0 carries the index, byte 1 the attributes
	assign indexSlot = reqD.valid && !reqD.addr[0];
	assign attrSlot = reqD.valid && reqD.addr[0];

	// only the two low attribute bits reach the ROM
	assign tileAttr = ramData[1:0];

	////////////////////////////////////////////////////////////
	// graphics ROM address
	////////////////////////////////////////////////////////////

	// index from the previous slot, row and nibble from the byte 1 request
	assign nextGfxAddr = {tileAttr, tileIndex, reqD.tileRow, reqD.nibble};

	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			reqD <= '0;
			tileIndex <= '0;
			gfxOut <= '0;
		end else begin
			reqD <= ramReq;

			// stage 2, latch index
			if (indexSlot)
				tileIndex <= ramData;

			// stage 3, one ROM address per slot pair
			gfxOut.valid <= attrSlot;
			if (attrSlot) begin
				// layer bit is the RAM address msb
				gfxOut.layer <= reqD.addr[12];
				gfxOut.addr <= nextGfxAddr;
			end
		end
	end

endmodule

// ==== verilog/tileRam.sv ====
`timescale 1ns/1ps

module tileRam
	import videoPkg::*;
	import cpuBusPkg::*;
(
	input  logic         CLK_6M,
	input  tileRamAddrT  videoAddr,
	output logic [7:0]   videoData,
	input  cpuRamAccessT cpuRam,
	output logic [7:0]   cpuRdata
);

	// layer 0 in the low 4k, layer 1 in the high 4k
	// two bytes per tile, index then attributes
	logic [7:0] mem [0:TILE_RAM_DEPTH-1];

	////////////////////////////////////////////////////////////
	// CPU port
	////////////////////////////////////////////////////////////

	// write on the access phase edge
	always_ff @(posedge CLK_6M) begin
		if (cpuRam.en && cpuRam.we)
			mem[cpuRam.addr] <= cpuRam.wdata;
	end

	// combinational read, APB returns it in the access cycle
	assign cpuRdata = mem[cpuRam.addr];

	////////////////////////////////////////////////////////////
	// video port
	////////////////////////////////////////////////////////////

	// one clock read latency
	// a same cycle CPU write lands after this read, so old byte wins
	always_ff @(posedge CLK_6M) begin
		videoData <= mem[videoAddr];
	end

endmodule

// ==== verilog/tilemapGenTop.sv ====
`timescale 1ns/1ps

module tilemapGenTop
	import videoPkg::*;
	import cpuBusPkg::*;
(
	input  logic                      CLK_6M,
	input  logic                      rst,
	input  logic                      nHsync,
	input  logic                      nVsync,
	input  apbReqT                    apbReq,
	output apbRspT                    apbRsp,
	output tileRamAddrT               ramAddr,
	output gfxOutT                    gfxOut,
	output priorityT [LAYER_COUNT-1:0] layerPriority
);

	hCountT                       hCount;
	vCountT                       vCount;
	layerScrollT [LAYER_COUNT-1:0] scroll;
	cpuRamAccessT                 cpuRam;
	logic [7:0]                   cpuRamRdata;
	ramReqT                       ramReq;
	logic [7:0]                   ramData;

	// screen position
	videoTiming u_videoTiming (
		.CLK_6M (CLK_6M),
		.rst    (rst),
		.nHsync (nHsync),
		.nVsync (nVsync),
		.hCount (hCount),
		.vCount (vCount)
	);

	// CPU registers and RAM window
	layerCtrlRegs u_layerCtrlRegs (
		.CLK_6M        (CLK_6M),
		.rst           (rst),
		.apbReq        (apbReq),
		.apbRsp        (apbRsp),
		.scroll        (scroll),
		.layerPriority (layerPriority),
		.cpuRam        (cpuRam),
		.cpuRamRdata   (cpuRamRdata)
	);

	////////////////////////////////////////////////////////////
	// fetch pipeline, counters to ROM address in 3 clocks
	////////////////////////////////////////////////////////////

	scrollAddrStage u_scrollAddrStage (
		.CLK_6M (CLK_6M),
		.rst    (rst),
		.hCount (hCount),
		.vCount (vCount),
		.scroll (scroll),
		.ramReq (ramReq)
	);

	tileRam u_tileRam (
		.CLK_6M    (CLK_6M),
		.videoAddr (ramReq.addr),
		.videoData (ramData),
		.cpuRam    (cpuRam),
		.cpuRdata  (cpuRamRdata)
	);

	tileFetchStage u_tileFetchStage (
		.CLK_6M  (CLK_6M),
		.rst     (rst),
		.ramReq  (ramReq),
		.ramData (ramData),
		.gfxOut  (gfxOut)
	);

	// registered stage 1 address
	assign ramAddr = ramReq.addr;

endmodule

// ==== verilog/videoPkg.sv ====
package videoPkg;

	////////////////////////////////////////////////////////////
	// screen and tilemap geometry
	////////////////////////////////////////////////////////////

	// two scroll layers, slot selected by hCount bit 1
	localparam int LAYER_COUNT = 2;
	// both layers share one 8k byte tilemap RAM
	localparam int TILE_RAM_DEPTH = 8192;

	// pixel and line counters
	typedef logic [8:0] hCountT;
	typedef logic [8:0] vCountT;

	// per-layer scroll offsets, vertical wraps at 256 lines
	typedef logic [8:0] hScrollT;
	typedef logic [7:0] vScrollT;
	typedef logic [2:0] priorityT;

	// {layer, row[4:0], column[5:0], byte}
	typedef logic [12:0] tileRamAddrT;
	typedef logic [7:0] tileIndexT;
	typedef logic [1:0] tileAttrT;
	// {attr[1:0], index[7:0], tileRow[2:0], nibble}
	typedef logic [13:0] gfxAddrT;

	////////////////////////////////////////////////////////////
	// pipeline structs
	////////////////////////////////////////////////////////////

	typedef struct packed {
		hScrollT hScroll;
		vScrollT vScroll;
	} layerScrollT;

	// stage 1 to stage 2, row and nibble ride along for the ROM address
	typedef struct packed {
		logic        valid;
		tileRamAddrT addr;
		logic [2:0]  tileRow;
		logic        nibble;
	} ramReqT;

	typedef struct packed {
		logic    valid;
		logic    layer;
		gfxAddrT addr;
	} gfxOutT;

endpackage

// ==== verilog/videoTiming.sv ====
`timescale 1ns/1ps

module videoTiming
	import videoPkg::*;
(
	input  logic   CLK_6M,
	input  logic   rst,
	input  logic   nHsync,
	input  logic   nVsync,
	output hCountT hCount,
	output vCountT vCount
);

	// previous sync levels
	logic hsyncLast;
	logic vsyncLast;
	logic hFall;
	logic vFall;

	// falling edge, current input low and last level high
	assign hFall = !nHsync && hsyncLast;
	assign vFall = !nVsync && vsyncLast;

	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			hsyncLast <= 1'b0;
			vsyncLast <= 1'b0;
		end else begin
			hsyncLast <= nHsync;
			vsyncLast <= nVsync;
		end
	end

	////////////////////////////////////////////////////////////
	// pixel and line counters
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			hCount <= '0;
			vCount <= '0;
		end else begin
			// new line on hsync fall, otherwise one pixel per clock
			if (hFall)
				hCount <= '0;
			else
				hCount <= hCount + 1'b1;

			// frame restart wins over the line step
			if (vFall)
				vCount <= '0;
			else if (hFall)
				vCount <= vCount + 1'b1;
		end
	end

endmodule
